// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN = 32;                        // Data path width

    // ALU control codes, same encoding as the core's ALU
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,                        // Also BEQ compare
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SLL    = 4'b0101,
        ALU_SRL    = 4'b0110,
        ALU_SLT    = 4'b0111,                        // Also BLT compare
        ALU_SLTU   = 4'b1000,                        // Also BLTU compare
        ALU_SRA    = 4'b1001,
        ALU_SUB_NE = 4'b1010,                        // BNE, taken on not zero
        ALU_SLT_GE = 4'b1011                         // BGE, taken on zero
    } alu_op_t;

    // Major opcodes handled by the cluster
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct7 values for OP and the shift immediates
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;     // SUB and SRA

    // Arithmetic funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;      // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;         // Not supported here

endpackage

// File: common/exec_pkg.sv
package exec_pkg;

    import rv_isa_pkg::*;

    localparam int NUM_LANES  = 2;                   // Issue slots, lane 0 is oldest
    localparam int REG_ADDR_W = 5;                   // Architectural register index

    // One fetched instruction with its operands
    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
    } issue_slot_t;

    // Decoded request for one execution lane
    typedef struct packed {
        logic                  valid;
        alu_op_t               op;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;                // rs2 or I-immediate
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm_b;                // Branch offset
        logic                  is_branch;
    } lane_req_t;

    // Registered lane output
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  we;
        logic                  taken;
        logic [XLEN-1:0]       target;
    } lane_res_t;

    // Register file write port
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// File: exec_lane/alu.sv
`timescale 1ns/1ns

module alu
    import rv_isa_pkg::*;
(
    input  logic [XLEN-1:0] src_a_i,
    input  logic [XLEN-1:0] src_b_i,
    input  alu_op_t         alu_control_i,
    output logic [XLEN-1:0] alu_result_o,
    output logic            zero_o
);

    logic [4:0] shamt;

    assign shamt = src_b_i[4:0];                     // Only low 5 bits shift

    always_comb begin
        case (alu_control_i)
            ALU_ADD: begin
                alu_result_o = src_a_i + src_b_i;
            end
            ALU_SUB, ALU_SUB_NE: begin
                alu_result_o = src_a_i - src_b_i;    // Equality by zero flag
            end
            ALU_AND: begin
                alu_result_o = src_a_i & src_b_i;
            end
            ALU_OR: begin
                alu_result_o = src_a_i | src_b_i;
            end
            ALU_XOR: begin
                alu_result_o = src_a_i ^ src_b_i;
            end
            ALU_SLL: begin
                alu_result_o = src_a_i << shamt;
            end
            ALU_SRL: begin
                alu_result_o = src_a_i >> shamt;
            end
            ALU_SRA: begin
                alu_result_o = $signed(src_a_i) >>> shamt;
            end
            ALU_SLT, ALU_SLT_GE: begin
                alu_result_o = ($signed(src_a_i) < $signed(src_b_i)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                alu_result_o = (src_a_i < src_b_i) ? 32'd1 : 32'd0;
            end
            default: begin
                alu_result_o = '0;                   // Unknown code
            end
        endcase
    end

    // The branch sense is resolved in the lane, the flag itself is never inverted
    assign zero_o = (alu_result_o == '0);

endmodule

// File: exec_lane/exec_lane.sv
`timescale 1ns/1ns

module exec_lane
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  lane_req_t req_i,
    output lane_res_t res_o
);

    logic [XLEN-1:0]       alu_result;
    logic                  zero;
    logic                  cond;
    logic [XLEN-1:0]       target;

    logic                  valid_q;
    logic                  we_q;
    logic                  taken_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       result_q;
    logic [XLEN-1:0]       target_q;

    alu alu_i (
        .src_a_i       (req_i.src_a),
        .src_b_i       (req_i.src_b),
        .alu_control_i (req_i.op),
        .alu_result_o  (alu_result),
        .zero_o        (zero)
    );

    always_comb begin
        case (req_i.op)
            ALU_SUB, ALU_SLT_GE:           cond = zero;    // BEQ, BGE
            ALU_SUB_NE, ALU_SLT, ALU_SLTU: cond = !zero;   // BNE, BLT, BLTU
            default:                       cond = 1'b0;
        endcase
    end

    assign target = req_i.pc + req_i.imm_b;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            we_q    <= 1'b0;
            taken_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
            we_q    <= req_i.valid && !req_i.is_branch && (req_i.rd != '0);  // x0 stays 0
            taken_q <= req_i.valid && req_i.is_branch && cond;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_q     <= req_i.rd;
        result_q <= alu_result;
        target_q <= target;
    end

    assign res_o = '{
        valid:  valid_q,
        rd:     rd_q,
        result: result_q,
        we:     we_q,
        taken:  taken_q,
        target: target_q
    };

endmodule

// File: src/issue_decode.sv
`timescale 1ns/1ns

module issue_decode
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  issue_slot_t          slot_i [NUM_LANES],
    output lane_req_t            req_o [NUM_LANES],
    output logic [NUM_LANES-1:0] illegal_o
);

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_slot
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [XLEN-1:0]       imm_i;
        logic [XLEN-1:0]       imm_b;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_t               op;
        logic                  legal;
        logic                  use_imm;
        logic                  branch;

        assign opcode = slot_i[k].instr[6:0];
        assign funct3 = slot_i[k].instr[14:12];
        assign funct7 = slot_i[k].instr[31:25];
        assign imm_i  = {{20{slot_i[k].instr[31]}}, slot_i[k].instr[31:20]};
        assign imm_b  = {{19{slot_i[k].instr[31]}}, slot_i[k].instr[31], slot_i[k].instr[7],
                         slot_i[k].instr[30:25], slot_i[k].instr[11:8], 1'b0};
        assign rd     = branch ? '0 : slot_i[k].instr[11:7];  // Branch rd bits are offset

        always_comb begin
            legal   = 1'b1;
            op      = ALU_ADD;
            use_imm = 1'b0;
            branch  = 1'b0;
            case (opcode)
                OPC_OP: begin
                    case (funct3)
                        F3_ADD_SUB: op = funct7[5] ? ALU_SUB : ALU_ADD;
                        F3_SLL:     op = ALU_SLL;
                        F3_SLT:     op = ALU_SLT;
                        F3_SLTU:    op = ALU_SLTU;
                        F3_XOR:     op = ALU_XOR;
                        F3_SR:      op = funct7[5] ? ALU_SRA : ALU_SRL;
                        F3_OR:      op = ALU_OR;
                        F3_AND:     op = ALU_AND;
                    endcase
                    legal = (funct7 == F7_BASE) ||
                            (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SR));
                end
                OPC_OP_IMM: begin
                    use_imm = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: op = ALU_ADD;            // No SUBI
                        F3_SLL:     op = ALU_SLL;
                        F3_SLT:     op = ALU_SLT;
                        F3_SLTU:    op = ALU_SLTU;
                        F3_XOR:     op = ALU_XOR;
                        F3_SR:      op = funct7[5] ? ALU_SRA : ALU_SRL;
                        F3_OR:      op = ALU_OR;
                        F3_AND:     op = ALU_AND;
                    endcase
                    if (funct3 == F3_SLL) begin
                        legal = (funct7 == F7_BASE);
                    end else if (funct3 == F3_SR) begin
                        legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                end
                OPC_BRANCH: begin
                    branch = 1'b1;
                    case (funct3)
                        F3_BEQ:  op = ALU_SUB;
                        F3_BNE:  op = ALU_SUB_NE;
                        F3_BLT:  op = ALU_SLT;
                        F3_BGE:  op = ALU_SLT_GE;
                        F3_BLTU: op = ALU_SLTU;
                        F3_BGEU: legal = 1'b0;               // No ALU code for it
                        default: legal = 1'b0;               // Reserved encodings
                    endcase
                end
                default: legal = 1'b0;
            endcase
        end

        assign req_o[k] = '{
            valid:     slot_i[k].valid && legal,
            op:        op,
            src_a:     slot_i[k].rs1_val,
            src_b:     use_imm ? imm_i : slot_i[k].rs2_val,
            rd:        rd,
            pc:        slot_i[k].pc,
            imm_b:     imm_b,
            is_branch: branch
        };
        assign illegal_o[k] = slot_i[k].valid && !legal;     // Empty slots never flag
    end

endmodule

// File: src/result_collect.sv
`timescale 1ns/1ns

module result_collect
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  lane_res_t            res_i [NUM_LANES],
    input  logic [NUM_LANES-1:0] illegal_i,
    output wb_t                  wb_o [NUM_LANES],
    output logic                 redirect_valid_o,
    output logic [XLEN-1:0]      redirect_pc_o,
    output logic [NUM_LANES-1:0] illegal_o
);

    logic                  squash;
    logic [NUM_LANES-1:0]  we_n;
    logic                  redir_valid_n;
    logic [XLEN-1:0]       redir_pc_n;

    logic [NUM_LANES-1:0]  illegal_d;
    logic [NUM_LANES-1:0]  illegal_q;
    logic [NUM_LANES-1:0]  we_q;
    logic [REG_ADDR_W-1:0] rd_q [NUM_LANES];
    logic [XLEN-1:0]       data_q [NUM_LANES];
    logic                  redirect_valid_q;
    logic [XLEN-1:0]       redirect_pc_q;

    // Oldest lane first, the first taken branch kills everything younger
    always_comb begin
        squash        = 1'b0;
        we_n          = '0;
        redir_valid_n = 1'b0;
        redir_pc_n    = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            we_n[k] = res_i[k].valid && res_i[k].we && !squash;
            if (res_i[k].valid && res_i[k].taken && !squash) begin
                redir_valid_n = 1'b1;
                redir_pc_n    = res_i[k].target;
                squash        = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            illegal_d        <= '0;
            illegal_q        <= '0;
            we_q             <= '0;
            redirect_valid_q <= 1'b0;
        end else begin
            illegal_d        <= illegal_i;       // Matches the lane register stage
            illegal_q        <= illegal_d;
            we_q             <= we_n;
            redirect_valid_q <= redir_valid_n;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            rd_q[k]   <= res_i[k].rd;
            data_q[k] <= res_i[k].result;
        end
        redirect_pc_q <= redir_pc_n;
    end

    // Same rd on both ports is left to the register file, lane 1 wins there
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            wb_o[k] = '{we: we_q[k], rd: rd_q[k], data: data_q[k]};
        end
    end

    assign redirect_valid_o = redirect_valid_q;
    assign redirect_pc_o    = redirect_pc_q;
    assign illegal_o        = illegal_q;

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/1ns

module exec_cluster
    import rv_isa_pkg::*;
    import exec_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  issue_slot_t          slot_i [NUM_LANES],
    output wb_t                  wb_o [NUM_LANES],
    output logic                 redirect_valid_o,
    output logic [XLEN-1:0]      redirect_pc_o,
    output logic [NUM_LANES-1:0] illegal_o
);

    lane_req_t            req [NUM_LANES];
    lane_res_t            res [NUM_LANES];
    logic [NUM_LANES-1:0] illegal;           // Combinational, from decode

    issue_decode issue_decode_i (
        .slot_i    (slot_i),
        .req_o     (req),
        .illegal_o (illegal)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        exec_lane exec_lane_i (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (req[k]),
            .res_o   (res[k])
        );
    end

    result_collect result_collect_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .res_i            (res),
        .illegal_i        (illegal),
        .wb_o             (wb_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .illegal_o        (illegal_o)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;                   // 10 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);                 // Two reset edges
        rst_n_o <= 1'b1;
    end

endmodule

// File: verification/exec_cluster_chk.sv
`timescale 1ns/1ns

module exec_cluster_chk
    import exec_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input wb_t       wb_i [NUM_LANES],
    input logic      redirect_valid_i,
    input lane_res_t res_i [NUM_LANES]
);

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_port
        a_no_x0_write: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            wb_i[k].we |-> (wb_i[k].rd != '0)
        ) else $error("write enable set for register x0 on port %0d", k);
    end

    a_redirect_after_reset: assert property (
        @(posedge clk_i) !rst_n_i |=> !redirect_valid_i
    ) else $error("redirect valid high in the cycle after reset");

    // Lane 0 result enters the collector one edge before the outputs
    a_lane1_squash: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (res_i[0].valid && res_i[0].taken) |=> (redirect_valid_i && !wb_i[1].we)
    ) else $error("lane 1 written behind a taken branch in lane 0");

endmodule

// File: verification/exec_cluster_tb.sv
`timescale 1ns/1ns

module exec_cluster_tb
    import rv_isa_pkg::*;
    import exec_pkg::*;
();

    typedef struct packed {
        logic        illegal;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
    } outcome_t;

    typedef struct packed {
        logic [31:0]                due;         // Cycle count at which outputs are sampled
        logic [NUM_LANES-1:0]       we;
        logic [NUM_LANES-1:0][4:0]  rd;
        logic [NUM_LANES-1:0][31:0] data;
        logic                       redirect;
        logic [31:0]                redirect_pc;
        logic [NUM_LANES-1:0]       illegal;
    } expect_t;

    logic                 clk;
    logic                 rst_n;
    issue_slot_t          slot [NUM_LANES];
    wb_t                  wb [NUM_LANES];
    logic                 redirect_valid;
    logic [XLEN-1:0]      redirect_pc;
    logic [NUM_LANES-1:0] illegal;

    expect_t     exp_q [$];
    logic [31:0] lcg_state = 32'd804;
    issue_slot_t idle = '0;
    int          cycle = 0;
    int          cycle_limit;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          rr_count = 40;
    int          imm_count = 24;
    int          b2b_count = 32;
    int          directed_count = 60;                // Upper bound of fixed bundles

    logic [6:0]  rr_f7 [10] = '{F7_BASE, F7_ALT, F7_BASE, F7_BASE, F7_BASE,
                                F7_BASE, F7_BASE, F7_ALT, F7_BASE, F7_BASE};
    logic [2:0]  rr_f3 [10] = '{F3_ADD_SUB, F3_ADD_SUB, F3_AND, F3_OR, F3_XOR,
                                F3_SLL, F3_SR, F3_SR, F3_SLT, F3_SLTU};
    logic [2:0]  imm_f3 [6] = '{F3_ADD_SUB, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
    logic [2:0]  br_f3 [5]  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU};
    logic [31:0] pair_a [7] = '{32'd5, 32'd3, 32'd9, 32'h8000_0000, 32'h7FFF_FFFF,
                                32'hFFFF_FFFF, 32'd1};
    logic [31:0] pair_b [7] = '{32'd5, 32'd9, 32'd3, 32'h7FFF_FFFF, 32'h8000_0000,
                                32'd1, 32'hFFFF_FFFF};

    tb_clk_gen tb_clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exec_cluster exec_cluster_i (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .slot_i           (slot),
        .wb_o             (wb),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc),
        .illegal_o        (illegal)
    );

    bind exec_cluster exec_cluster_chk exec_cluster_chk_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .wb_i             (wb_o),
        .redirect_valid_i (redirect_valid_o),
        .res_i            (res)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd);
        return {imm, 5'd1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic issue_slot_t make_slot(logic v, logic [31:0] instr,
                                              logic [31:0] a, logic [31:0] b);
        issue_slot_t s;
        logic [31:0] r;
        r         = lcg_next();
        s.valid   = v;
        s.instr   = instr;
        s.pc      = {r[31:2], 2'b00};                // Word aligned
        s.rs1_val = a;
        s.rs2_val = b;
        return s;
    endfunction

    // Architectural result of one slot, straight from the RV32I rules
    function automatic outcome_t outcome_of(issue_slot_t s);
        outcome_t    o;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_b;
        logic        legal;
        logic        branch;
        logic        alt;
        logic        cond;
        opc    = s.instr[6:0];
        f3     = s.instr[14:12];
        f7     = s.instr[31:25];
        a      = s.rs1_val;
        b      = s.rs2_val;
        imm_b  = {{19{s.instr[31]}}, s.instr[31], s.instr[7], s.instr[30:25],
                  s.instr[11:8], 1'b0};
        legal  = 1'b0;
        branch = 1'b0;
        alt    = 1'b0;
        cond   = 1'b0;
        if (opc == OPC_OP) begin
            legal = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SR));
            alt   = f7[5];
        end else if (opc == OPC_OP_IMM) begin
            b     = {{20{s.instr[31]}}, s.instr[31:20]};
            legal = (f3 == F3_SLL) ? (f7 == F7_BASE) :
                    (f3 == F3_SR)  ? (f7 == F7_BASE || f7 == F7_ALT) : 1'b1;
            alt   = (f3 == F3_SR) && f7[5];          // ADDI has no subtract form
        end else if (opc == OPC_BRANCH) begin
            branch = 1'b1;
            legal  = f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU};
        end
        case (f3)
            F3_ADD_SUB: o.data = alt ? a - b : a + b;
            F3_SLL:     o.data = a << b[4:0];
            F3_SLT:     o.data = {31'd0, $signed(a) < $signed(b)};
            F3_SLTU:    o.data = {31'd0, a < b};
            F3_XOR:     o.data = a ^ b;
            F3_SR:      o.data = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      o.data = a | b;
            default:    o.data = a & b;
        endcase
        case (f3)
            F3_BEQ:  cond = (a == b);
            F3_BNE:  cond = (a != b);
            F3_BLT:  cond = ($signed(a) < $signed(b));
            F3_BGE:  cond = ($signed(a) >= $signed(b));
            F3_BLTU: cond = (a < b);
            default: cond = 1'b0;
        endcase
        o.rd      = s.instr[11:7];
        o.illegal = s.valid && !legal;
        o.we      = s.valid && legal && !branch && (o.rd != 5'd0);
        o.taken   = s.valid && legal && branch && cond;
        o.target  = s.pc + imm_b;
        return o;
    endfunction

    function automatic expect_t predict(issue_slot_t s0, issue_slot_t s1);
        expect_t  e;
        outcome_t o0;
        outcome_t o1;
        o0            = outcome_of(s0);
        o1            = outcome_of(s1);
        e             = '0;
        e.we[0]       = o0.we;
        e.we[1]       = o1.we && !o0.taken;          // Older taken branch kills lane 1
        e.rd[0]       = o0.rd;
        e.rd[1]       = o1.rd;
        e.data[0]     = o0.data;
        e.data[1]     = o1.data;
        e.redirect    = o0.taken || o1.taken;
        e.redirect_pc = o0.taken ? o0.target : o1.target;
        e.illegal     = {o1.illegal, o0.illegal};
        return e;
    endfunction

    function automatic issue_slot_t random_slot(int kind);
        logic [31:0] r;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        int          sel;
        r   = lcg_next();
        sel = int'(r[31:16]);
        a   = lcg_next();
        b   = lcg_next();
        if (kind == 0) begin
            instr = enc_r(rr_f7[sel % 10], rr_f3[sel % 10], r[24:20]);
            if (r[3]) begin
                b[4:0] = 5'd31;                      // Shift amount of 31 and above
            end
            return make_slot(1'b1, instr, a, b);
        end else if (kind == 1) begin
            if (sel % 8 < 6) begin
                instr = enc_i({1'b1, r[14:4]}, imm_f3[sel % 8], r[24:20]);  // Negative
            end else begin
                instr = enc_i({r[5] ? F7_ALT : F7_BASE, r[10:6]}, F3_SR, r[24:20]);
            end
            return make_slot(1'b1, instr, a, b);
        end
        instr = enc_b({r[27:16], 1'b0}, br_f3[sel % 5]);
        return make_slot(1'b1, instr, a, r[2] ? a : b);
    endfunction

    task automatic check_equal(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic issue(issue_slot_t s0, issue_slot_t s1);
        expect_t e;
        @(negedge clk);
        slot[0] = s0;
        slot[1] = s1;
        e       = predict(s0, s1);
        e.due   = 32'(cycle + 2);                    // Lane stage, then collector stage
        exp_q.push_back(e);
    endtask

    task automatic drain();
        issue(idle, idle);
        issue(idle, idle);
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report(string name, int chk_before, int err_before);
        tests++;
        $display("Test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - chk_before, errors - err_before);
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("Timeout: results still pending after %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (exp_q.size() != 0 && exp_q[0].due == 32'(cycle)) begin
            e = exp_q.pop_front();
            for (int k = 0; k < NUM_LANES; k++) begin
                check_equal($sformatf("wb_o[%0d].we", k), 32'(wb[k].we), 32'(e.we[k]));
                if (e.we[k]) begin
                    check_equal($sformatf("wb_o[%0d].rd", k), 32'(wb[k].rd), 32'(e.rd[k]));
                    check_equal($sformatf("wb_o[%0d].data", k), wb[k].data, e.data[k]);
                end
            end
            check_equal("redirect_valid_o", 32'(redirect_valid), 32'(e.redirect));
            if (e.redirect) begin
                check_equal("redirect_pc_o", redirect_pc, e.redirect_pc);
            end
            check_equal("illegal_o", 32'(illegal), 32'(e.illegal));
        end
    end

    initial begin
        int          c0;
        int          e0;
        logic [31:0] rnd;
        slot[0]     = '0;
        slot[1]     = '0;
        cycle_limit = 2 + rr_count + imm_count + b2b_count + directed_count + 7 * 4 + 50;
        @(posedge rst_n);
        @(negedge clk);

        c0 = checks;
        e0 = errors;
        for (int k = 0; k < NUM_LANES; k++) begin
            check_equal($sformatf("wb_o[%0d].we", k), 32'(wb[k].we), 32'd0);
        end
        check_equal("redirect_valid_o", 32'(redirect_valid), 32'd0);
        check_equal("illegal_o", 32'(illegal), 32'd0);
        report("reset_state", c0, e0);

        c0 = checks;
        e0 = errors;
        issue(make_slot(1'b1, enc_r(F7_BASE, F3_SLL, 5'd3), 32'h8000_0001, 32'd31),
              make_slot(1'b1, enc_r(F7_ALT, F3_SR, 5'd4), 32'h8000_0000, 32'd32));
        issue(make_slot(1'b1, enc_r(F7_BASE, F3_SR, 5'd5), 32'hF000_000F, 32'd63),
              make_slot(1'b1, enc_r(F7_ALT, F3_SR, 5'd6), 32'h8000_0000, 32'hFFFF_FFFF));
        for (int i = 0; i < rr_count; i++) begin
            issue(random_slot(0), random_slot(0));
        end
        drain();
        report("reg_reg_alu", c0, e0);

        c0 = checks;
        e0 = errors;
        issue(make_slot(1'b1, enc_i(12'hFFF, F3_ADD_SUB, 5'd1), 32'd0, 32'd0),
              make_slot(1'b1, enc_i(12'hFFF, F3_SLTU, 5'd2), 32'h1234_5678, 32'd0));
        issue(make_slot(1'b1, enc_i(12'h800, F3_SLT, 5'd3), 32'd0, 32'd0),
              make_slot(1'b1, enc_i(12'hF00, F3_AND, 5'd4), 32'hFFFF_FFFF, 32'd0));
        for (int i = 0; i < imm_count; i++) begin
            issue(random_slot(1), random_slot(1));
        end
        drain();
        report("immediate_forms", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int f = 0; f < 5; f++) begin
            for (int p = 0; p < 7; p++) begin
                rnd = lcg_next();
                issue(make_slot(1'b1, enc_b({rnd[27:16], 1'b0}, br_f3[f]),
                                pair_a[p], pair_b[p]), idle);
            end
        end
        drain();
        report("branches", c0, e0);

        c0 = checks;
        e0 = errors;
        issue(make_slot(1'b1, enc_b(13'h010, F3_BEQ), 32'd7, 32'd7),
              make_slot(1'b1, enc_r(F7_BASE, F3_ADD_SUB, 5'd5), 32'd1, 32'd2));
        issue(make_slot(1'b1, enc_b(13'h1F00, F3_BLT), 32'hFFFF_FFFF, 32'd0),
              make_slot(1'b1, enc_b(13'h040, F3_BNE), 32'd1, 32'd2));
        issue(make_slot(1'b1, enc_b(13'h020, F3_BNE), 32'd3, 32'd3),
              make_slot(1'b1, enc_b(13'h080, F3_BLTU), 32'd1, 32'hFFFF_FFFF));
        issue(make_slot(1'b1, enc_r(F7_BASE, F3_OR, 5'd6), 32'h0F0F_0000, 32'h0000_F0F0),
              make_slot(1'b1, enc_b(13'h0FFC, F3_BGE), 32'd4, 32'd4));
        issue(make_slot(1'b0, enc_b(13'h010, F3_BEQ), 32'd0, 32'd0),
              make_slot(1'b1, enc_b(13'h100, F3_BEQ), 32'd9, 32'd9));
        issue(make_slot(1'b1, enc_r(F7_BASE, F3_ADD_SUB, 5'd7), 32'd10, 32'd20),
              make_slot(1'b1, enc_r(F7_ALT, F3_ADD_SUB, 5'd7), 32'd10, 32'd20));
        drain();
        report("age_squash", c0, e0);

        c0 = checks;
        e0 = errors;
        issue(make_slot(1'b1, enc_b(13'h020, F3_BGEU), 32'd5, 32'd1),
              make_slot(1'b1, enc_r(F7_BASE, F3_ADD_SUB, 5'd9), 32'd1, 32'd1));
        issue(make_slot(1'b1, enc_r(F7_BASE, F3_ADD_SUB, 5'd0), 32'd1, 32'd1),
              make_slot(1'b1, 32'h0000_2083, 32'd0, 32'd0));           // LW
        issue(make_slot(1'b1, 32'h1234_50B7, 32'd0, 32'd0),            // LUI
              make_slot(1'b1, 32'h0000_006F, 32'd0, 32'd0));           // JAL
        issue(make_slot(1'b1, enc_r(7'b0000001, F3_ADD_SUB, 5'd8), 32'd3, 32'd4),
              make_slot(1'b1, enc_i({F7_ALT, 5'd3}, F3_SLL, 5'd8), 32'd3, 32'd0));
        issue(make_slot(1'b0, 32'h0000_006F, 32'd0, 32'd0),
              make_slot(1'b1, enc_i(12'd5, F3_ADD_SUB, 5'd0), 32'd1, 32'd0));
        issue(make_slot(1'b1, enc_b(13'h010, 3'b010), 32'd1, 32'd1),
              make_slot(1'b1, enc_r(F7_ALT, F3_SR, 5'd0), 32'h8000_0000, 32'd4));
        drain();
        report("illegal_and_x0", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < b2b_count; i++) begin
            issue(random_slot(int'(lcg_next() >> 30) % 3),
                  random_slot(int'(lcg_next() >> 30) % 3));
        end
        drain();
        report("back_to_back", c0, e0);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sim.f
common/rv_isa_pkg.sv
common/exec_pkg.sv
exec_lane/alu.sv
exec_lane/exec_lane.sv
src/issue_decode.sv
src/result_collect.sv
src/exec_cluster.sv
verification/tb_clk_gen.sv
verification/exec_cluster_chk.sv
verification/exec_cluster_tb.sv

// File: Makefile
# Verilator build and run of the execute cluster testbench

VERILATOR ?= verilator
TOP       ?= exec_cluster_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
FAIL_MSG  ?= Finished with errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and scan $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	@$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
